//--- bench/organ_vectors.txt
# op sw(hex) keys(hex mask, 1=pressed) hold(repeat periods) label(ASCII hex)
# half(hex cycles) off_sample(hex) scope_count(hex)
TONE  001 0 4   444F2020 5F 80 0030D3
TONE  003 0 4   52452020 55 80 0030D3
TONE  005 0 4   4D492020 4B 80 0030D3
TONE  007 0 4   534F2020 3F 80 0030D3
TONE  009 0 4   46412020 47 80 0030D3
TONE  00B 0 4   4C412020 38 80 0030D3
TONE  00D 0 4   53492020 32 80 0030D3
TONE  00F 0 4   444F4820 2F 80 0030D3
TONE  00E 0 2   20202020 2F 80 0030D3
TONE  00F 0 2   444F4820 2F 80 0030D3
HOLD  001 1 3   444F2020 5F 80 0031FF
HOLD  001 2 5   444F2020 5F 80 00300B
HOLD  001 3 4   444F2020 5F 80 00300B
CLEAR 001 4 1   444F2020 5F 80 0030D3
HOLD  005 1 125 4D492020 4B 80 005FB3
CLEAR 005 4 1   4D492020 4B 80 0030D3
HOLD  005 2 125 4D492020 4B 80 0001F3
CLEAR 000 4 1   20202020 5F 80 0030D3
IDLE  000 0 2   20202020 5F 80 0030D3

//--- project.f
common/organ_pkg.sv
tone/note_decode.sv
tone/tone_synth.sv
speed/speed_control.sv
source/status_display.sv
source/organ_top.sv
bench/organ_checker.sv
bench/organ_tb.sv

//--- Bender.yml
package:
  name: organ

sources:
  - common/organ_pkg.sv
  - tone/note_decode.sv
  - tone/tone_synth.sv
  - speed/speed_control.sv
  - source/status_display.sv
  - source/organ_top.sv
  - target: simulation
    files:
      - bench/organ_checker.sv
      - bench/organ_tb.sv

//--- bench/organ_tb.sv
`timescale 1ns/10ps

module organ_tb;

  localparam int unsigned CLK_HZ     = 100_000;
  localparam int unsigned REPEAT_HZ  = 1_000;
  localparam int unsigned REFRESH_HZ = 2_000;

  localparam int REPEAT_CYCLES  = CLK_HZ / REPEAT_HZ;  // 100 cycles
  localparam int SETTLE_CYCLES  = REPEAT_CYCLES;       // Key latency plus one refresh
  localparam int MAX_TESTS      = 32;
  localparam int TIMEOUT_MARGIN = 500;
  localparam VECTOR_FILE = "bench/organ_vectors.txt";

  typedef struct packed {
    logic [9:0]               sw;
    logic [2:0]               key_mask;   // 1 = key pressed
    logic [15:0]              hold;       // In repeat periods
    organ_pkg::label_t        label;
    organ_pkg::count_t        half;
    organ_pkg::sample_t       off_sample;
    organ_pkg::scope_count_t  scope;
  } vector_t;

  logic                  CLK_50M;
  logic                  rst_n;
  logic [9:0]            sw;
  logic [2:0]            keys;
  organ_pkg::sample_t    audio_sample;
  organ_pkg::seg_bank_t  digits;
  organ_pkg::label_t     note_text;
  organ_pkg::label_t     power_text;

  vector_t  vectors [MAX_TESTS];
  vector_t  current;               // Expected values of the running test
  logic     test_begin;
  logic     test_end;
  int       test_id;
  int       num_tests;
  int       load_errors;
  int       pass_count;
  int       fail_count;
  int       cycle_count;
  int       timeout_cycles;

  organ_top #(
    .CLK_HZ     (CLK_HZ),
    .REPEAT_HZ  (REPEAT_HZ),
    .REFRESH_HZ (REFRESH_HZ)
  ) uut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .keys         (keys),
    .audio_sample (audio_sample),
    .digits       (digits),
    .note_text    (note_text),
    .power_text   (power_text)
  );

  organ_checker monitor (
    .CLK_50M      (CLK_50M),
    .test_begin   (test_begin),
    .test_end     (test_end),
    .test_id      (test_id),
    .test_sw      (current.sw),
    .exp_label    (current.label),
    .exp_half     (current.half),
    .exp_off      (current.off_sample),
    .exp_scope    (current.scope),
    .audio_sample (audio_sample),
    .digits       (digits),
    .note_text    (note_text),
    .power_text   (power_text),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Watchdog
  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (cycle_count > timeout_cycles)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ============================================================
  // Vector loading
  // ============================================================
  task automatic load_vectors;
    int           fd;
    int           fields;
    int           hold_v;
    string        line;
    logic [39:0]  op;
    logic [9:0]   sw_v;
    logic [2:0]   mask_v;
    logic [31:0]  label_v;
    logic [31:0]  half_v;
    logic [7:0]   off_v;
    logic [23:0]  scope_v;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0)
    begin
      $display("error: cannot open the vector file %s", VECTOR_FILE);
      load_errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() < 2 || line.getc(0) == "#")
        continue;                                        // Blank or comment
      fields = $sscanf(line, "%s %h %h %d %h %h %h %h", op, sw_v, mask_v, hold_v,
                       label_v, half_v, off_v, scope_v);
      if (fields != 8 || hold_v < 1 ||
          (op != "TONE" && op != "HOLD" && op != "CLEAR" && op != "IDLE"))
      begin
        $display("error: malformed vector line: %s", line);
        load_errors++;
      end
      else if (num_tests == MAX_TESTS)
      begin
        $display("error: more than %0d vectors in the file", MAX_TESTS);
        load_errors++;
      end
      else
      begin
        vectors[num_tests] = {sw_v, mask_v, hold_v[15:0], label_v, half_v, off_v, scope_v};
        num_tests++;
      end
    end
    $fclose(fd);
  endtask

  // Press the keys for the hold length, release, then let the display refresh
  task automatic run_test(input int idx);
    vector_t v;
    v = vectors[idx];
    @(posedge CLK_50M);
    #2;
    current    = v;
    test_id    = idx + 1;
    sw         = v.sw;
    keys       = ~v.key_mask;
    test_begin = 1'b1;
    @(posedge CLK_50M);
    #2;
    test_begin = 1'b0;
    repeat (v.hold * REPEAT_CYCLES - 1) @(posedge CLK_50M);
    #2;
    keys = 3'b111;
    repeat (SETTLE_CYCLES) @(posedge CLK_50M);
    #2;
    test_end = 1'b1;
    @(posedge CLK_50M);
    #2;
    test_end = 1'b0;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin
    rst_n          = 1'b0;
    sw             = '0;
    keys           = 3'b111;
    test_begin     = 1'b0;
    test_end       = 1'b0;
    test_id        = 0;
    current        = '0;
    num_tests      = 0;
    load_errors    = 0;
    cycle_count    = 0;
    timeout_cycles = TIMEOUT_MARGIN;
    load_vectors();
    for (int i = 0; i < num_tests; i++)
      timeout_cycles += vectors[i].hold * REPEAT_CYCLES + SETTLE_CYCLES + 4;
    repeat (4) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < num_tests; i++)
      run_test(i);
    repeat (2) @(posedge CLK_50M);
    $display("tests %0d, passed %0d, failed %0d, load errors %0d",
             num_tests, pass_count, fail_count, load_errors);
    if (num_tests > 0 && fail_count == 0 && load_errors == 0 && pass_count == num_tests)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- bench/organ_checker.sv
`timescale 1ns/10ps

module organ_checker (
  input  logic                     CLK_50M,
  input  logic                     test_begin,    // One cycle at test start
  input  logic                     test_end,      // One cycle when the test is over
  input  int                       test_id,
  input  logic [9:0]               test_sw,
  input  organ_pkg::label_t        exp_label,
  input  organ_pkg::count_t        exp_half,
  input  organ_pkg::sample_t       exp_off,
  input  organ_pkg::scope_count_t  exp_scope,
  input  organ_pkg::sample_t       audio_sample,
  input  organ_pkg::seg_bank_t     digits,
  input  organ_pkg::label_t        note_text,
  input  organ_pkg::label_t        power_text,
  output int                       pass_count,
  output int                       fail_count
);

  localparam int SETTLE_CYCLES = 4;  // Sample needs a cycle or two after a switch change

  logic                active;
  logic                sound;
  logic                sample_reported;   // Only the first sample error is printed
  int                  cyc;
  int                  last_edge;
  int                  edge_count;
  int                  test_errors;
  organ_pkg::sample_t  prev_sample;

  initial
  begin
    active     = 1'b0;
    pass_count = 0;
    fail_count = 0;
  end

  // Lit segments as gfedcba, turned active low on return
  function automatic organ_pkg::seg_t seg_pattern(input logic [3:0] value);
    logic [6:0] lit;
    case (value)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    seg_pattern = ~lit;
  endfunction

  // ============================================================
  // Per-cycle sample checks
  // ============================================================
  task automatic check_sample;
    int spacing;
    if (!sound)
    begin
      if (audio_sample !== exp_off)
      begin
        if (!sample_reported)
          $display("mismatch audio_sample: got %h expected %h", audio_sample, exp_off);
        sample_reported = 1'b1;
        test_errors++;
      end
    end
    else if (audio_sample !== organ_pkg::SAMPLE_HIGH && audio_sample !== organ_pkg::SAMPLE_LOW)
    begin
      if (!sample_reported)
        $display("mismatch audio_sample: got %h expected 7f or 80", audio_sample);
      sample_reported = 1'b1;
      test_errors++;
    end
    else if (audio_sample !== prev_sample)
    begin
      spacing = cyc - last_edge;
      if (edge_count > 0 && spacing != exp_half)
      begin
        if (!sample_reported)
          $display("mismatch audio_sample half-period: got %h expected %h", spacing, exp_half);
        sample_reported = 1'b1;
        test_errors++;
      end
      last_edge = cyc;
      edge_count++;
    end
  endtask

  // ============================================================
  // End-of-test checks and report line
  // ============================================================
  task automatic close_test;
    organ_pkg::label_t  want_power;
    organ_pkg::seg_t    want_seg;
    want_power = sound ? 32'h4F4E2020 : 32'h4F464620;  // "ON  " or "OFF "
    if (note_text !== exp_label)
    begin
      $display("mismatch note_text: got %h expected %h", note_text, exp_label);
      test_errors++;
    end
    if (power_text !== want_power)
    begin
      $display("mismatch power_text: got %h expected %h", power_text, want_power);
      test_errors++;
    end
    for (int i = 0; i < 6; i++)
    begin
      want_seg = seg_pattern(exp_scope[i*4 +: 4]);
      if (digits[i*7 +: 7] !== want_seg)
      begin
        $display("mismatch digits.hex%0d: got %h expected %h", i, digits[i*7 +: 7], want_seg);
        test_errors++;
      end
    end
    if (sound && edge_count < 2)
    begin
      $display("test %0d: the tone never completed a full half-period", test_id);
      test_errors++;
    end
    if (test_errors == 0)
    begin
      $display("test %0d sw %h: ok", test_id, test_sw);
      pass_count++;
    end
    else
    begin
      $display("test %0d sw %h: failed with %0d errors", test_id, test_sw, test_errors);
      fail_count++;
    end
  endtask

  always @(posedge CLK_50M)
  begin
    if (test_begin)
    begin
      active          = 1'b1;
      sound           = test_sw[0];
      cyc             = 0;
      last_edge       = 0;
      edge_count      = 0;
      test_errors     = 0;
      sample_reported = 1'b0;
      prev_sample     = audio_sample;
    end
    else if (active)
    begin
      cyc++;
      if (cyc > SETTLE_CYCLES)
        check_sample();
      prev_sample = audio_sample;
      if (test_end)
      begin
        close_test();
        active = 1'b0;
      end
    end
  end

endmodule

//--- source/organ_top.sv
`timescale 1ns/10ps

module organ_top #(
  parameter int unsigned CLK_HZ     = 50_000_000,
  parameter int unsigned REPEAT_HZ  = 10,
  parameter int unsigned REFRESH_HZ = 2
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [9:0]            sw,
  input  logic [2:0]            keys,          // Active low
  output organ_pkg::sample_t    audio_sample,
  output organ_pkg::seg_bank_t  digits,
  output organ_pkg::label_t     note_text,
  output organ_pkg::label_t     power_text
);

  // Switch fields
  logic                  sound_on;
  organ_pkg::note_sel_t  note_sel;

  organ_pkg::note_cfg_t     note_cfg;
  organ_pkg::scope_count_t  scope_count;

  assign sound_on = sw[0];
  assign note_sel = sw[3:1];

  // ==========================================================
  // Note selection
  // ==========================================================
  note_decode #(
    .CLK_HZ (CLK_HZ)
  ) u_note_decode (
    .note_sel (note_sel),
    .note_cfg (note_cfg)
  );

  // ==========================================================
  // Tone synthesis and speed control
  // ==========================================================
  tone_synth u_tone_synth (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sound_on    (sound_on),
    .half_period (note_cfg.half_period),
    .sample      (audio_sample)
  );

  speed_control #(
    .CLK_HZ    (CLK_HZ),
    .REPEAT_HZ (REPEAT_HZ)
  ) u_speed_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .keys        (keys),
    .scope_count (scope_count)
  );

  // ==========================================================
  // Status display
  // ==========================================================
  status_display #(
    .CLK_HZ     (CLK_HZ),
    .REFRESH_HZ (REFRESH_HZ)
  ) u_status_display (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sound_on    (sound_on),
    .note_name   (note_cfg.name),
    .scope_count (scope_count),
    .digits      (digits),
    .note_text   (note_text),
    .power_text  (power_text)
  );

endmodule

//--- source/status_display.sv
`timescale 1ns/10ps

module status_display #(
  parameter int unsigned CLK_HZ     = 50_000_000,
  parameter int unsigned REFRESH_HZ = 2
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic                     sound_on,
  input  organ_pkg::label_t        note_name,
  input  organ_pkg::scope_count_t  scope_count,
  output organ_pkg::seg_bank_t     digits,
  output organ_pkg::label_t        note_text,
  output organ_pkg::label_t        power_text
);

  localparam int unsigned REFRESH_CYCLES = CLK_HZ / REFRESH_HZ;
  localparam int unsigned REFRESH_W      = $clog2(REFRESH_CYCLES + 1);
  localparam logic [REFRESH_W-1:0] REFRESH_LAST = REFRESH_W'(REFRESH_CYCLES - 1);

  logic [REFRESH_W-1:0]     refresh_cnt;
  organ_pkg::scope_count_t  shown_count;   // Value on the digits

  // Hex nibble to active-low segments, g..a
  function automatic organ_pkg::seg_t hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0:    hex_to_seg = 7'b1000000;
      4'h1:    hex_to_seg = 7'b1111001;
      4'h2:    hex_to_seg = 7'b0100100;
      4'h3:    hex_to_seg = 7'b0110000;
      4'h4:    hex_to_seg = 7'b0011001;
      4'h5:    hex_to_seg = 7'b0010010;
      4'h6:    hex_to_seg = 7'b0000010;
      4'h7:    hex_to_seg = 7'b1111000;
      4'h8:    hex_to_seg = 7'b0000000;
      4'h9:    hex_to_seg = 7'b0010000;
      4'hA:    hex_to_seg = 7'b0001000;
      4'hB:    hex_to_seg = 7'b0000011;  // Lower case b
      4'hC:    hex_to_seg = 7'b1000110;
      4'hD:    hex_to_seg = 7'b0100001;  // Lower case d
      4'hE:    hex_to_seg = 7'b0000110;
      default: hex_to_seg = 7'b0001110;
    endcase
  endfunction

  // ==========================================================
  // Refresh latch
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      shown_count <= '0;                 // All digits read 0
    end
    else if (refresh_cnt == REFRESH_LAST)
    begin
      refresh_cnt <= '0;
      shown_count <= scope_count;
    end
    else
    begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Six decoders, hex0 is the lowest nibble
  assign digits.hex0 = hex_to_seg(shown_count[3:0]);
  assign digits.hex1 = hex_to_seg(shown_count[7:4]);
  assign digits.hex2 = hex_to_seg(shown_count[11:8]);
  assign digits.hex3 = hex_to_seg(shown_count[15:12]);
  assign digits.hex4 = hex_to_seg(shown_count[19:16]);
  assign digits.hex5 = hex_to_seg(shown_count[23:20]);

  // ==========================================================
  // Text labels
  // ==========================================================
  assign note_text = sound_on ? note_name
                              : {4{organ_pkg::CHAR_SPACE}};

  assign power_text = sound_on
    ? {organ_pkg::CHAR_O, organ_pkg::CHAR_N, organ_pkg::CHAR_SPACE, organ_pkg::CHAR_SPACE}
    : {organ_pkg::CHAR_O, organ_pkg::CHAR_F, organ_pkg::CHAR_F, organ_pkg::CHAR_SPACE};

endmodule

//--- speed/speed_control.sv
`timescale 1ns/10ps

module speed_control #(
  parameter int unsigned CLK_HZ    = 50_000_000,
  parameter int unsigned REPEAT_HZ = 10
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic [2:0]               keys,         // Active low: up, down, clear
  output organ_pkg::scope_count_t  scope_count
);

  localparam int unsigned REPEAT_CYCLES = CLK_HZ / REPEAT_HZ;
  localparam int unsigned PACE_W        = $clog2(REPEAT_CYCLES + 1);
  localparam logic [PACE_W-1:0] PACE_LAST = PACE_W'(REPEAT_CYCLES - 1);

  logic [2:0]         key_meta;
  logic [2:0]         key_sync;
  logic               up_held;
  logic               down_held;
  logic               clear_held;

  logic [PACE_W-1:0]  pace_cnt;
  logic               tick;

  organ_pkg::speed_t  speed;

  // ==========================================================
  // Key synchronizers
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~keys;     // Pressed becomes 1
      key_sync <= key_meta;
    end
  end

  assign up_held    = key_sync[0];
  assign down_held  = key_sync[1];
  assign clear_held = key_sync[2];

  // ==========================================================
  // Repeat pacing
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      pace_cnt <= '0;
    else if (tick)
      pace_cnt <= '0;
    else
      pace_cnt <= pace_cnt + 1'b1;
  end

  assign tick = (pace_cnt == PACE_LAST);  // One cycle per repeat period

  // ==========================================================
  // Speed register
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      speed <= '0;
    else if (clear_held)
      speed <= '0;                       // Wins over any step
    else if (tick)
    begin
      if (up_held && !down_held)
      begin
        if (speed > organ_pkg::SPEED_LIMIT - organ_pkg::SPEED_STEP)
          speed <= organ_pkg::SPEED_LIMIT;
        else
          speed <= speed + organ_pkg::SPEED_STEP;
      end
      else if (down_held && !up_held)
      begin
        if (speed < organ_pkg::SPEED_STEP - organ_pkg::SPEED_LIMIT)
          speed <= -organ_pkg::SPEED_LIMIT;
        else
          speed <= speed - organ_pkg::SPEED_STEP;
      end
    end
  end

  // Sampling count is the default plus the sign-extended offset
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      scope_count <= organ_pkg::DEFAULT_SCOPE_COUNT;
    else
      scope_count <= organ_pkg::DEFAULT_SCOPE_COUNT + {{8{speed[15]}}, speed};
  end

endmodule

//--- tone/tone_synth.sv
`timescale 1ns/10ps

module tone_synth (
  input  logic                CLK_50M,
  input  logic                rst_n,
  input  logic                sound_on,
  input  organ_pkg::count_t   half_period,
  output organ_pkg::sample_t  sample
);

  organ_pkg::count_t  phase_cnt;   // Cycles left in this half-period
  organ_pkg::count_t  last_half;   // Copy used to spot a note change
  logic               phase;       // Square-wave level

  // ==========================================================
  // Phase generator
  // ==========================================================
  // Counts half_period-1 down to 0, so the phase flips every half_period cycles
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      phase_cnt <= '0;
      last_half <= '0;
      phase     <= 1'b0;
    end
    else if (!sound_on)
    begin
      phase_cnt <= '0;                 // Held clear while silent
      last_half <= half_period;
      phase     <= 1'b0;
    end
    else if (half_period != last_half)
    begin
      // New note, restart the count
      phase_cnt <= half_period - organ_pkg::count_t'(1);
      last_half <= half_period;
    end
    else if (phase_cnt == '0)
    begin
      phase_cnt <= half_period - organ_pkg::count_t'(1);
      phase     <= ~phase;
    end
    else
    begin
      phase_cnt <= phase_cnt - organ_pkg::count_t'(1);
    end
  end

  // ==========================================================
  // Sample register
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample <= organ_pkg::SAMPLE_LOW;
    else if (sound_on && phase)
      sample <= organ_pkg::SAMPLE_HIGH;
    else
      sample <= organ_pkg::SAMPLE_LOW;  // Low half, or sound off
  end

endmodule

//--- tone/note_decode.sv
`timescale 1ns/10ps

module note_decode #(
  parameter int unsigned CLK_HZ = 50_000_000
) (
  input  organ_pkg::note_sel_t  note_sel,
  output organ_pkg::note_cfg_t  note_cfg
);

  // Half-period counts, fixed at elaboration
  organ_pkg::count_t half_table [8];

  // CLK_HZ / (2 * f), integer part
  for (genvar i = 0; i < 8; i++)
  begin : g_half_table
    assign half_table[i] = organ_pkg::count_t'(CLK_HZ / (2 * organ_pkg::NOTE_HZ[i]));
  end

  // Plain lookup, no state
  always_comb
  begin
    note_cfg.half_period = half_table[note_sel];
    note_cfg.name        = organ_pkg::NOTE_NAMES[note_sel];  // Padded with spaces
  end

endmodule

//--- common/organ_pkg.sv
package organ_pkg;

  // ==========================================================
  // Widths that carry a meaning
  // ==========================================================
  typedef logic signed [7:0]  sample_t;       // Signed audio sample
  typedef logic        [31:0] count_t;        // Half-period length in clock cycles
  typedef logic signed [15:0] speed_t;        // Scope speed offset
  typedef logic        [23:0] scope_count_t;  // Shown as six hex digits
  typedef logic        [7:0]  char_t;         // One ASCII code
  typedef logic        [31:0] label_t;        // Four characters, first in top byte
  typedef logic        [6:0]  seg_t;          // Active low, segment a in bit 0
  typedef logic        [2:0]  note_sel_t;     // Note switch code

  // Six digits, most significant first
  typedef struct packed {
    seg_t hex5;
    seg_t hex4;
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } seg_bank_t;

  typedef struct packed {
    count_t half_period;
    label_t name;
  } note_cfg_t;

  // ==========================================================
  // Constants
  // ==========================================================
  localparam speed_t       SPEED_STEP          = 16'sd100;
  localparam speed_t       SPEED_LIMIT         = 16'sd12000;
  localparam scope_count_t DEFAULT_SCOPE_COUNT = 24'd12499;  // 2 kHz scope rate

  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;  // Also the silent level

  // Characters used by the labels
  localparam char_t CHAR_SPACE = 8'h20;
  localparam char_t CHAR_A     = 8'h41;
  localparam char_t CHAR_D     = 8'h44;
  localparam char_t CHAR_E     = 8'h45;
  localparam char_t CHAR_F     = 8'h46;
  localparam char_t CHAR_H     = 8'h48;
  localparam char_t CHAR_I     = 8'h49;
  localparam char_t CHAR_L     = 8'h4C;
  localparam char_t CHAR_M     = 8'h4D;
  localparam char_t CHAR_N     = 8'h4E;
  localparam char_t CHAR_O     = 8'h4F;
  localparam char_t CHAR_R     = 8'h52;
  localparam char_t CHAR_S     = 8'h53;

  // ==========================================================
  // Note table, indexed by switch code
  // ==========================================================
  // Codes 011 and 100 are swapped relative to pitch order
  localparam int unsigned NOTE_HZ [8] = '{523, 587, 659, 783, 698, 880, 987, 1046};

  localparam label_t NOTE_NAMES [8] = '{
    {CHAR_D, CHAR_O, CHAR_SPACE, CHAR_SPACE},  // 000
    {CHAR_R, CHAR_E, CHAR_SPACE, CHAR_SPACE},  // 001
    {CHAR_M, CHAR_I, CHAR_SPACE, CHAR_SPACE},  // 010
    {CHAR_S, CHAR_O, CHAR_SPACE, CHAR_SPACE},  // 011
    {CHAR_F, CHAR_A, CHAR_SPACE, CHAR_SPACE},  // 100
    {CHAR_L, CHAR_A, CHAR_SPACE, CHAR_SPACE},  // 101
    {CHAR_S, CHAR_I, CHAR_SPACE, CHAR_SPACE},  // 110
    {CHAR_D, CHAR_O, CHAR_H,     CHAR_SPACE}   // 111, high C
  };

endpackage
